/* requant_macros.svh */
// ****************************************
// Requantization unit widths
// Data, scale, fraction and counter sizes
// shared by the package and all RTL blocks
// ****************************************

`ifndef REQUANT_MACROS_SVH
`define REQUANT_MACROS_SVH

// Sample and output width
`define RQ_DATA_W 16

// Scale width in signed fixed point
`define RQ_SCALE_W 16

// Product fraction bits dropped by the rounder
`define RQ_FRAC_W 8

// Saturation event counter width
`define RQ_CNT_W 16

`endif

/* requant_pkg.sv */
// ****************************************
// Requantization types
// Sample, scale, product and rounded value
// types plus the output clamp limits
// ****************************************

`include "requant_macros.svh"

package requant_pkg;

	// Incoming sample and outgoing result
	typedef logic signed [`RQ_DATA_W-1:0] sample_t;

	// Multiplier held in the control block
	typedef logic signed [`RQ_SCALE_W-1:0] scale_t;

	// Full precision product with no bits lost
	typedef logic signed [`RQ_DATA_W+`RQ_SCALE_W-1:0] product_t;

	// Integer part after rounding
	// One extra top bit keeps the pre-round sign
	typedef logic signed [`RQ_DATA_W+`RQ_SCALE_W-`RQ_FRAC_W:0] rounded_t;

	// ****************************************
	// Output clamp limits
	// ****************************************

	// Largest positive output 0111...1
	localparam sample_t sat_max = {1'b0, {(`RQ_DATA_W-1){1'b1}}};

	// Most negative output 1000...0
	localparam sample_t sat_min = {1'b1, {(`RQ_DATA_W-1){1'b0}}};

endpackage

/* rne_rounder.sv */
// ****************************************
// Round half to even
// Drops the low fraction bits of a product
// and flags a carry into the sign bit
// ****************************************

`timescale 1ns/10ps

`include "requant_macros.svh"

module rne_rounder import requant_pkg::*;
#(
	parameter int in_width = `RQ_DATA_W + `RQ_SCALE_W,
	parameter int frac_bits = `RQ_FRAC_W,
	parameter bit is_unsigned = 1'b0
)
(
	input product_t product,
	output rounded_t rounded,
	output logic round_ovf
);

	// Integer part plus one guard bit on top
	localparam int int_w = in_width - frac_bits + 1;

	logic [in_width:0] ext;
	logic [int_w-1:0] int_part;
	logic [int_w-1:0] sum;
	logic [frac_bits-1:0] frac;
	logic half;
	logic rest_zero;
	logic inc;

	// Guard bit is a sign copy, or zero when unsigned
	assign ext = {(is_unsigned ? 1'b0 : product[in_width-1]), product[in_width-1:0]};

	// Split into kept integer and dropped fraction
	assign int_part = ext[in_width:frac_bits];
	assign frac = ext[frac_bits-1:0];

	// Half bit and sticky of the rest
	assign half = frac[frac_bits-1];
	assign rest_zero = (frac[frac_bits-2:0] == '0);

	// Above half rounds up, exact half goes to the even neighbor
	always_comb
	begin
		inc = 1'b0;
		if (half)
		begin
			if (rest_zero)
				inc = int_part[0];
			else
				inc = 1'b1;
		end
	end

	assign sum = int_part + {{(int_w-1){1'b0}}, inc};
	assign rounded = rounded_t'(sum);

	// Carry that sets the sign bit of the kept integer
	always_comb
	begin
		if (is_unsigned)
			round_ovf = ~int_part[int_w-1] & sum[int_w-1];
		else
			round_ovf = ~int_part[int_w-2] & sum[int_w-2];
	end

endmodule

/* scale_multiplier.sv */
// ****************************************
// Scale multiplier
// Registered signed product of the sample
// and the held scale, full precision
// ****************************************

`timescale 1ns/10ps

`include "requant_macros.svh"

module scale_multiplier import requant_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic stage1_en,
	input sample_t in_data,
	input scale_t scale,
	output product_t product
);

	// Both operands widened to product size first
	product_t data_ext;
	product_t scale_ext;
	product_t mult;

	// Sign extension of the sample
	assign data_ext = product_t'(in_data);

	// Sign extension of the scale
	assign scale_ext = product_t'(scale);

	// Width of the product covers every operand pair
	assign mult = data_ext * scale_ext;

	// ****************************************
	// Stage 1 register
	// ****************************************

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			product <= '0;
		end
		else if (stage1_en)
		begin
			// Only a strobed sample moves the register
			product <= mult;
		end
	end

endmodule

/* saturator.sv */
// ****************************************
// Output saturator
// Clamps the rounded value to the output
// width and flags every clamp event
// ****************************************

`timescale 1ns/10ps

`include "requant_macros.svh"

module saturator import requant_pkg::*;
#(
	parameter bit is_unsigned = 1'b0
)
(
	input logic clk,
	input logic rst,
	input logic stage2_en,
	input rounded_t rounded,
	input logic round_ovf,
	output sample_t out_data,
	output logic sat_flag
);

	localparam int top = $bits(rounded_t) - 1;

	sample_t clamp;
	logic over;

	always_comb
	begin
		clamp = rounded[`RQ_DATA_W-1:0];
		over = 1'b0;
		if (is_unsigned)
		begin
			// Any bit above the output width is too large
			if (round_ovf || (|rounded[top:`RQ_DATA_W]))
			begin
				clamp = '1;
				over = 1'b1;
			end
		end
		else if (round_ovf)
		begin
			// Top bit still holds the sign before rounding
			clamp = rounded[top] ? sat_min : sat_max;
			over = 1'b1;
		end
		else if (rounded > rounded_t'(sat_max))
		begin
			clamp = sat_max;
			over = 1'b1;
		end
		else if (rounded < rounded_t'(sat_min))
		begin
			clamp = sat_min;
			over = 1'b1;
		end
	end

	// Stage 2 register
	always_ff @(posedge clk)
	begin
		if (stage2_en)
			out_data <= clamp;
		if (rst)
			sat_flag <= 1'b0;
		else if (stage2_en)
			sat_flag <= over;
	end

endmodule

/* requant_ctrl.sv */
// ****************************************
// Requantization control
// Holds the scale, runs the two stage valid
// pipeline and counts saturation events
// ****************************************

`timescale 1ns/10ps

`include "requant_macros.svh"

module requant_ctrl import requant_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic cfg_strobe,
	input scale_t cfg_scale,
	input logic in_valid,
	input logic sat_flag,
	output scale_t scale,
	output logic stage1_en,
	output logic stage2_en,
	output logic out_valid,
	output logic [`RQ_CNT_W-1:0] sat_count
);

	// Unity scale of one in fixed point
	localparam scale_t scale_one = scale_t'(1 << `RQ_FRAC_W);

	// ****************************************
	// Scale register
	// ****************************************

	// New scale applies to samples strobed on later cycles
	always_ff @(posedge clk)
	begin
		if (rst)
			scale <= scale_one;
		else if (cfg_strobe)
			scale <= cfg_scale;
	end

	// ****************************************
	// Valid pipeline
	// ****************************************

	// Multiplier samples on the strobe cycle itself
	assign stage1_en = in_valid;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			stage2_en <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			stage2_en <= in_valid;
			out_valid <= stage2_en;
		end
	end

	// Saturation counter that stops at all ones
	always_ff @(posedge clk)
	begin
		if (rst)
			sat_count <= '0;
		else if (out_valid && sat_flag && (sat_count != '1))
			sat_count <= sat_count + 1'b1;
	end

endmodule

/* requant_top.sv */
// ****************************************
// Requantization unit top
// Multiply by scale, round half to even,
// saturate, two cycle latency
// ****************************************

`timescale 1ns/10ps

`include "requant_macros.svh"

module requant_top import requant_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic cfg_strobe,
	input scale_t cfg_scale,
	input logic in_valid,
	input sample_t in_data,
	output logic out_valid,
	output sample_t out_data,
	output logic [`RQ_CNT_W-1:0] sat_count
);

	// Rounder and saturator share one signedness
	localparam bit rq_unsigned = 1'b0;

	// Control to datapath
	scale_t scale;
	logic stage1_en;
	logic stage2_en;

	// Datapath internals
	product_t product;
	rounded_t rounded;
	logic round_ovf;
	logic sat_flag;

	requant_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.cfg_strobe(cfg_strobe),
		.cfg_scale(cfg_scale),
		.in_valid(in_valid),
		.sat_flag(sat_flag),
		.scale(scale),
		.stage1_en(stage1_en),
		.stage2_en(stage2_en),
		.out_valid(out_valid),
		.sat_count(sat_count)
	);

	// Stage 1
	scale_multiplier u_mult (
		.clk(clk),
		.rst(rst),
		.stage1_en(stage1_en),
		.in_data(in_data),
		.scale(scale),
		.product(product)
	);

	// Combinational between the stages
	rne_rounder #(.is_unsigned(rq_unsigned)) u_round (
		.product(product),
		.rounded(rounded),
		.round_ovf(round_ovf)
	);

	// Stage 2
	saturator #(.is_unsigned(rq_unsigned)) u_sat (
		.clk(clk),
		.rst(rst),
		.stage2_en(stage2_en),
		.rounded(rounded),
		.round_ovf(round_ovf),
		.out_data(out_data),
		.sat_flag(sat_flag)
	);

endmodule

/* tb_requant_properties.sv */
// ****************************************
// Requantization unit assertions
// Reset state, latency, clamp values and
// saturation counter steps, bound to top
// ****************************************

`timescale 1ns/10ps

`include "requant_macros.svh"

module tb_requant_properties import requant_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic stage2_en,
	input logic out_valid,
	input logic sat_flag,
	input sample_t out_data,
	input logic [`RQ_CNT_W-1:0] sat_count
);

	// One failure count per assertion
	int f_reset = 0;
	int f_latency = 0;
	int f_origin = 0;
	int f_clamp = 0;
	int f_count = 0;
	int fail_total;

	assign fail_total = f_reset + f_latency + f_origin + f_clamp + f_count;

	// Pipeline and counter cleared on a reset edge
	a_reset: assert property (@(posedge clk)
		rst |=> (!out_valid && !stage2_en && !sat_flag && (sat_count == '0)))
	else
	begin
		$error("pipeline or counter not cleared by reset");
		f_reset++;
	end

	// Every strobe comes out two cycles later
	a_latency: assert property (@(posedge clk) disable iff (rst)
		in_valid |-> ##2 out_valid)
	else
	begin
		$error("out_valid missing two cycles after in_valid");
		f_latency++;
	end

	// No output without a strobe two cycles back
	a_origin: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> $past(in_valid, 2))
	else
	begin
		$error("out_valid without a matching in_valid");
		f_origin++;
	end

	// A flagged output sits on one of the limits
	a_clamp: assert property (@(posedge clk) disable iff (rst)
		(out_valid && sat_flag) |-> ((out_data == sat_max) || (out_data == sat_min)))
	else
	begin
		$error("saturated output is not a limit value");
		f_clamp++;
	end

	// Counter steps by one per flagged output and holds otherwise
	a_count: assert property (@(posedge clk) disable iff (rst)
		1'b1 |=> (($past(out_valid && sat_flag) && ($past(sat_count) != '1)) ?
		(sat_count == $past(sat_count) + 1'b1) : (sat_count == $past(sat_count))))
	else
	begin
		$error("saturation counter stepped wrongly");
		f_count++;
	end

endmodule

bind requant_top tb_requant_properties props_i (
	.clk(clk),
	.rst(rst),
	.in_valid(in_valid),
	.stage2_en(stage2_en),
	.out_valid(out_valid),
	.sat_flag(sat_flag),
	.out_data(out_data),
	.sat_count(sat_count)
);

/* tb_requant.sv */
// ****************************************
// Requantization unit testbench
// Directed and LFSR stimulus checked against
// a model of multiply, round and clamp
// ****************************************

`timescale 1ns/10ps

`include "requant_macros.svh"

module tb_requant import requant_pkg::*;
();

	logic clk;
	logic rst;
	logic cfg_strobe;
	scale_t cfg_scale;
	logic in_valid;
	sample_t in_data;
	logic out_valid;
	sample_t out_data;
	logic [`RQ_CNT_W-1:0] sat_count;

	// Expected results in strobe order and model state
	sample_t exp_q[$];
	sample_t exp_head;
	scale_t model_scale;
	int exp_sats;
	int main_errs;
	int data_errs;
	int tests_run;
	int errs_before;
	string test_name;
	logic [31:0] lfsr;

	requant_top dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Galois LFSR stepped once per bit taken
	function automatic logic [15:0] random_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// Model result with a clamp flag in the top bit
	function automatic logic [16:0] model_out(input sample_t d, input scale_t s);
		longint p;
		longint q;
		longint r;
		p = longint'(d) * longint'(s);
		// Floor of the scaled value and the dropped remainder
		q = p >>> `RQ_FRAC_W;
		r = p - (q <<< `RQ_FRAC_W);
		if ((r > (1 << (`RQ_FRAC_W - 1))) || ((r == (1 << (`RQ_FRAC_W - 1))) && q[0]))
			q = q + 1;
		if (q > sat_max)
			return {1'b1, sat_max};
		if (q < sat_min)
			return {1'b1, sat_min};
		return {1'b0, q[15:0]};
	endfunction

	function automatic int total_errors();
		return main_errs + data_errs + dut_i.props_i.fail_total;
	endfunction

	// One clock of stimulus that queues the model result of a strobe
	task automatic drive_cycle(input logic v, input sample_t d, input logic c, input scale_t cs);
		logic [16:0] m;
		@(posedge clk);
		in_valid <= v;
		in_data <= d;
		cfg_strobe <= c;
		cfg_scale <= cs;
		if (v)
		begin
			m = model_out(d, model_scale);
			exp_q.push_back(m[15:0]);
			exp_sats += m[16];
		end
		// Same cycle strobe still sees the old scale
		if (c)
			model_scale = cs;
	endtask

	task automatic check_value(input string what, input longint exp, input longint act);
		assert (exp == act)
		else
		begin
			$display("Error: %s %s expected %0d actual %0d", test_name, what, exp, act);
			main_errs++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errs_before = total_errors();
	endtask

	// Waits for all pending outputs, then checks the counter
	task automatic finish_test();
		int n;
		int errs;
		n = 0;
		while (exp_q.size() != 0)
		begin
			@(posedge clk);
			n++;
			if (n > 100)
			begin
				$display("Timeout in test %s, expected outputs never arrived", test_name);
				$display("SIMULATION FAILED");
				$finish;
			end
		end
		repeat (2) @(posedge clk);
		check_value("sat_count", exp_sats, sat_count);
		errs = total_errors() - errs_before;
		tests_run++;
		$display("Test %-9s %s, %0d errors", test_name, (errs == 0) ? "ok" : "failed", errs);
	endtask

	// Output checker in strobe order
	always @(posedge clk)
	begin
		if (!rst && out_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Output in test %s without any sample pending", test_name);
				data_errs++;
			end
			else
			begin
				exp_head = exp_q.pop_front();
				assert (out_data == exp_head)
				else
				begin
					$display("Error: %s expected %0d actual %0d", test_name, exp_head, out_data);
					data_errs++;
				end
			end
		end
	end

	initial
	begin
		int i;
		logic [15:0] rv;
		sample_t rd;
		rst = 1'b1;
		cfg_strobe = 1'b0;
		cfg_scale = '0;
		in_valid = 1'b0;
		in_data = '0;
		lfsr = 32'h600b;
		model_scale = scale_t'(1 << `RQ_FRAC_W);
		exp_sats = 0;
		main_errs = 0;
		data_errs = 0;
		tests_run = 0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		// ****************************************
		// Directed tests
		// ****************************************

		start_test("reset");
		for (i = 0; i < 8; i++)
		begin
			@(posedge clk);
			check_value("out_valid", 0, out_valid);
		end
		finish_test();

		// Back to back strobes, then isolated ones at unity scale
		start_test("latency");
		for (i = 0; i < 6; i++)
			drive_cycle(1'b1, sample_t'(i * 37 - 90), 1'b0, '0);
		drive_cycle(1'b0, '0, 1'b0, '0);
		drive_cycle(1'b1, 16'sd1000, 1'b0, '0);
		drive_cycle(1'b0, '0, 1'b0, '0);
		drive_cycle(1'b0, '0, 1'b0, '0);
		drive_cycle(1'b1, -16'sd1000, 1'b0, '0);
		drive_cycle(1'b0, '0, 1'b0, '0);
		finish_test();

		// Scale 0.5 gives exact halves, 100/256 gives the rest
		start_test("rounding");
		drive_cycle(1'b0, '0, 1'b1, 16'sd128);
		for (i = -6; i <= 6; i++)
			drive_cycle(1'b1, sample_t'(i), 1'b0, '0);
		drive_cycle(1'b0, '0, 1'b1, 16'sd100);
		for (i = -8; i <= 8; i++)
			drive_cycle(1'b1, sample_t'(i), 1'b0, '0);
		drive_cycle(1'b0, '0, 1'b0, '0);
		finish_test();

		start_test("saturate");
		drive_cycle(1'b0, '0, 1'b1, 16'sh7fff);
		drive_cycle(1'b1, sat_max, 1'b0, '0);
		drive_cycle(1'b1, sat_min, 1'b0, '0);
		drive_cycle(1'b0, '0, 1'b1, 16'sh8000);
		drive_cycle(1'b1, sat_max, 1'b0, '0);
		drive_cycle(1'b1, sat_min, 1'b0, '0);
		// 32767.5 rounds up past the limit, -32767.5 lands on it
		drive_cycle(1'b0, '0, 1'b1, 16'sd257);
		drive_cycle(1'b1, 16'sd32640, 1'b0, '0);
		drive_cycle(1'b1, -16'sd32640, 1'b0, '0);
		drive_cycle(1'b0, '0, 1'b0, '0);
		finish_test();

		// Random burst at scale 4.0 where most large samples clamp
		start_test("counter");
		drive_cycle(1'b0, '0, 1'b1, 16'sh0400);
		for (i = 0; i < 48; i++)
		begin
			rv = random_bits(1);
			rd = random_bits(16);
			drive_cycle(rv[0], rd, 1'b0, '0);
		end
		drive_cycle(1'b0, '0, 1'b0, '0);
		finish_test();

		// New scale lands with a strobe in flight and one alongside
		start_test("scale");
		drive_cycle(1'b0, '0, 1'b1, 16'sd512);
		drive_cycle(1'b1, 16'sd100, 1'b0, '0);
		drive_cycle(1'b1, 16'sd100, 1'b1, 16'sd768);
		drive_cycle(1'b1, 16'sd100, 1'b0, '0);
		drive_cycle(1'b0, '0, 1'b1, -16'sd256);
		drive_cycle(1'b1, 16'sd100, 1'b0, '0);
		drive_cycle(1'b0, '0, 1'b0, '0);
		finish_test();

		$display("Tests %0d, check errors %0d, assertion failures %0d",
			tests_run, main_errs + data_errs, dut_i.props_i.fail_total);
		if (total_errors() == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* tb.f */
+incdir+.
requant_pkg.sv
rne_rounder.sv
scale_multiplier.sv
saturator.sv
requant_ctrl.sv
requant_top.sv
tb_requant_properties.sv
tb_requant.sv

/* Bender.yml */
package:
  name: requant

sources:
  - include_dirs:
      - .
    files:
      - requant_pkg.sv
      - rne_rounder.sv
      - scale_multiplier.sv
      - saturator.sv
      - requant_ctrl.sv
      - requant_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_requant_properties.sv
      - tb_requant.sv
